// File: common/simt_pkg.sv
// shared widths, ALU op codes and the execution-unit count, imported by every back-end module
`default_nettype none

package simt_pkg;

    // units merged by the commit arbiter, ALU first and multiplier second
    localparam int NUM_EX_UNITS = 2;

    // one lane's data word
    typedef logic [31:0] word_t;

    // architectural register index, 8 registers per warp
    typedef logic [2:0] reg_idx_t;

    // ALU operation code
    typedef logic [1:0] alu_op_t;

    localparam alu_op_t ALU_ADD = 2'd0;
    localparam alu_op_t ALU_SUB = 2'd1;
    localparam alu_op_t ALU_AND = 2'd2;
    localparam alu_op_t ALU_XOR = 2'd3;

    // retired thread-instruction counter
    typedef logic [31:0] instret_t;

endpackage

`default_nettype wire

// File: hw/alu_unit.sv
// lane-parallel ALU with one output register, turning issued ops into commit records
`timescale 1ns/1ps
`default_nettype none

module alu_unit import simt_pkg::*; #(
    parameter int NUM_THREADS = 4,
    parameter int NUM_WARPS = 4,
    localparam int WID_W = $clog2(NUM_WARPS)
) (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           in_valid,
    output logic                          in_ready,
    input  wire [WID_W-1:0]               in_wid,
    input  wire [NUM_THREADS-1:0]         in_tmask,
    input  wire reg_idx_t                 in_rd,
    input  wire                           in_wb,
    input  wire                           in_eop,
    input  wire alu_op_t                  in_op,
    input  wire word_t [NUM_THREADS-1:0]  in_a,
    input  wire word_t [NUM_THREADS-1:0]  in_b,
    output logic                          cm_valid,
    input  wire                           cm_ready,
    output logic [WID_W-1:0]              cm_wid,
    output logic [NUM_THREADS-1:0]        cm_tmask,
    output reg_idx_t                      cm_rd,
    output logic                          cm_wb,
    output logic                          cm_eop,
    output word_t [NUM_THREADS-1:0]       cm_data
);

    word_t [NUM_THREADS-1:0] result;

    // output slot free, or its record leaves this cycle
    assign in_ready = ~cm_valid | cm_ready;

    always_comb begin
        for (int i = 0; i < NUM_THREADS; i++) begin
            case (in_op)
                ALU_ADD: result[i] = in_a[i] + in_b[i];
                ALU_SUB: result[i] = in_a[i] - in_b[i];
                ALU_AND: result[i] = in_a[i] & in_b[i];
                default: result[i] = in_a[i] ^ in_b[i];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cm_valid <= 1'b0;
        end else if (in_ready) begin
            cm_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            cm_wid   <= in_wid;
            cm_tmask <= in_tmask;
            cm_rd    <= in_rd;
            cm_wb    <= in_wb;
            cm_eop   <= in_eop;
            cm_data  <= result;
        end
    end

    // a stalled record must not change under the arbiter
    a_hold_stalled: assert property (@(posedge clk) disable iff (reset)
        cm_valid && !cm_ready |=> cm_valid && $stable(cm_data))
        else $error("alu_unit: commit data changed while stalled");

endmodule

`default_nettype wire

// File: hw/mul_unit.sv
// two-stage lane-parallel 32-bit multiplier producing commit records with the low product word
`timescale 1ns/1ps
`default_nettype none

module mul_unit import simt_pkg::*; #(
    parameter int NUM_THREADS = 4,
    parameter int NUM_WARPS = 4,
    localparam int WID_W = $clog2(NUM_WARPS)
) (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           in_valid,
    output logic                          in_ready,
    input  wire [WID_W-1:0]               in_wid,
    input  wire [NUM_THREADS-1:0]         in_tmask,
    input  wire reg_idx_t                 in_rd,
    input  wire                           in_wb,
    input  wire                           in_eop,
    input  wire word_t [NUM_THREADS-1:0]  in_a,
    input  wire word_t [NUM_THREADS-1:0]  in_b,
    output logic                          cm_valid,
    input  wire                           cm_ready,
    output logic [WID_W-1:0]              cm_wid,
    output logic [NUM_THREADS-1:0]        cm_tmask,
    output reg_idx_t                      cm_rd,
    output logic                          cm_wb,
    output logic                          cm_eop,
    output word_t [NUM_THREADS-1:0]       cm_data
);

    logic                    s1_valid;
    logic [WID_W-1:0]        s1_wid;
    logic [NUM_THREADS-1:0]  s1_tmask;
    reg_idx_t                s1_rd;
    logic                    s1_wb;
    logic                    s1_eop;
    word_t [NUM_THREADS-1:0] s1_a;
    word_t [NUM_THREADS-1:0] s1_b;
    logic                    advance;

    // whole pipe moves together, frozen while the output is stalled
    assign advance  = ~cm_valid | cm_ready;
    assign in_ready = advance;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            cm_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= in_valid;
            cm_valid <= s1_valid;
        end
    end

    // operand capture
    always_ff @(posedge clk) begin
        if (advance && in_valid) begin
            s1_wid   <= in_wid;
            s1_tmask <= in_tmask;
            s1_rd    <= in_rd;
            s1_wb    <= in_wb;
            s1_eop   <= in_eop;
            s1_a     <= in_a;
            s1_b     <= in_b;
        end
    end

    // product stage, only the low word is kept
    always_ff @(posedge clk) begin
        if (advance && s1_valid) begin
            cm_wid   <= s1_wid;
            cm_tmask <= s1_tmask;
            cm_rd    <= s1_rd;
            cm_wb    <= s1_wb;
            cm_eop   <= s1_eop;
            for (int i = 0; i < NUM_THREADS; i++) begin
                cm_data[i] <= word_t'(s1_a[i] * s1_b[i]);
            end
        end
    end

endmodule

`default_nettype wire

// File: commit/commit_arb.sv
// round-robin arbiter with a registered output, merging the execution-unit record streams
`timescale 1ns/1ps
`default_nettype none

module commit_arb import simt_pkg::*; #(
    parameter int NUM_THREADS = 4,
    parameter int NUM_WARPS = 4,
    localparam int WID_W = $clog2(NUM_WARPS)
) (
    input  wire                                             clk,
    input  wire                                             reset,
    input  wire [NUM_EX_UNITS-1:0]                          in_valid,
    output logic [NUM_EX_UNITS-1:0]                         in_ready,
    input  wire [NUM_EX_UNITS-1:0][WID_W-1:0]               in_wid,
    input  wire [NUM_EX_UNITS-1:0][NUM_THREADS-1:0]         in_tmask,
    input  wire reg_idx_t [NUM_EX_UNITS-1:0]                in_rd,
    input  wire [NUM_EX_UNITS-1:0]                          in_wb,
    input  wire [NUM_EX_UNITS-1:0]                          in_eop,
    input  wire word_t [NUM_EX_UNITS-1:0][NUM_THREADS-1:0]  in_data,
    output logic                                            out_valid,
    input  wire                                             out_ready,
    output logic [WID_W-1:0]                                out_wid,
    output logic [NUM_THREADS-1:0]                          out_tmask,
    output reg_idx_t                                        out_rd,
    output logic                                            out_wb,
    output logic                                            out_eop,
    output word_t [NUM_THREADS-1:0]                         out_data
);

    localparam int IDX_W = (NUM_EX_UNITS > 1) ? $clog2(NUM_EX_UNITS) : 1;

    logic [IDX_W-1:0] prio;
    logic [IDX_W-1:0] grant_idx;
    logic             grant_any;
    logic             out_load;
    logic             in_fire;

    assign out_load = ~out_valid | out_ready;

    // scan from the lowest priority up so the last hit is the winner
    always_comb begin
        grant_any = 1'b0;
        grant_idx = prio;
        for (int i = NUM_EX_UNITS - 1; i >= 0; i--) begin
            if (in_valid[(int'(prio) + i) % NUM_EX_UNITS]) begin
                grant_any = 1'b1;
                grant_idx = IDX_W'((int'(prio) + i) % NUM_EX_UNITS);
            end
        end
    end

    always_comb begin
        for (int k = 0; k < NUM_EX_UNITS; k++) begin
            in_ready[k] = out_load && grant_any && (grant_idx == IDX_W'(k));
        end
    end

    assign in_fire = |(in_valid & in_ready);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            prio      <= '0;
        end else begin
            if (out_load) begin
                out_valid <= grant_any;
            end
            // winner drops to lowest priority
            if (in_fire) begin
                prio <= (grant_idx == IDX_W'(NUM_EX_UNITS - 1)) ? '0 : grant_idx + IDX_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_wid   <= in_wid[grant_idx];
            out_tmask <= in_tmask[grant_idx];
            out_rd    <= in_rd[grant_idx];
            out_wb    <= in_wb[grant_idx];
            out_eop   <= in_eop[grant_idx];
            out_data  <= in_data[grant_idx];
        end
    end

    a_ready_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(in_ready))
        else $error("commit_arb: more than one input granted");

    a_valid_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(out_valid))
        else $error("commit_arb: out_valid unknown after reset");

endmodule

`default_nettype wire

// File: commit/commit_stage.sv
// commit stage forwarding writeback, pulsing committed on eop and counting retired threads
`timescale 1ns/1ps
`default_nettype none

module commit_stage import simt_pkg::*; #(
    parameter int NUM_THREADS = 4,
    parameter int NUM_WARPS = 4,
    localparam int WID_W = $clog2(NUM_WARPS)
) (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           cm_valid,
    input  wire [WID_W-1:0]               cm_wid,
    input  wire [NUM_THREADS-1:0]         cm_tmask,
    input  wire reg_idx_t                 cm_rd,
    input  wire                           cm_wb,
    input  wire                           cm_eop,
    input  wire word_t [NUM_THREADS-1:0]  cm_data,
    output logic                          cm_ready,
    output logic                          wb_valid,
    output logic [WID_W-1:0]              wb_wid,
    output reg_idx_t                      wb_rd,
    output logic [NUM_THREADS-1:0]        wb_tmask,
    output word_t [NUM_THREADS-1:0]       wb_data,
    output logic                          committed,
    output logic [WID_W-1:0]              committed_wid,
    output instret_t                      instret
);

    localparam int COUNT_W = $clog2(NUM_THREADS + 1);

    logic               cm_fire;
    logic [COUNT_W-1:0] pop_count;
    logic               fire_r;
    logic               fire_rr;
    logic [COUNT_W-1:0] size_r;
    logic [COUNT_W-1:0] size_rr;

    // commit never stalls
    assign cm_ready = 1'b1;
    assign cm_fire  = cm_valid & cm_ready;

    // writeback goes out in the record's own cycle
    assign wb_valid = cm_valid & cm_wb;
    assign wb_wid   = cm_wid;
    assign wb_rd    = cm_rd;
    assign wb_tmask = cm_tmask;
    assign wb_data  = cm_data;

    // active lanes of the record
    always_comb begin
        pop_count = '0;
        for (int i = 0; i < NUM_THREADS; i++) begin
            pop_count = pop_count + COUNT_W'(cm_tmask[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fire_r  <= 1'b0;
            fire_rr <= 1'b0;
        end else begin
            fire_r  <= cm_fire;
            fire_rr <= fire_r;
        end
    end

    always_ff @(posedge clk) begin
        size_r  <= pop_count;
        size_rr <= size_r;
    end

    // instret lands 3 edges after acceptance
    always_ff @(posedge clk) begin
        if (reset) begin
            instret <= '0;
        end else if (fire_rr) begin
            instret <= instret + instret_t'(size_rr);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            committed <= 1'b0;
        end else begin
            committed <= cm_fire & cm_eop;
        end
    end

    always_ff @(posedge clk) begin
        committed_wid <= cm_wid;
    end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
// per-warp register file with a lane-masked write port and a combinational read port
`timescale 1ns/1ps
`default_nettype none

module reg_file import simt_pkg::*; #(
    parameter int NUM_THREADS = 4,
    parameter int NUM_WARPS = 4,
    localparam int WID_W = $clog2(NUM_WARPS)
) (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           wb_valid,
    input  wire [WID_W-1:0]               wb_wid,
    input  wire reg_idx_t                 wb_rd,
    input  wire [NUM_THREADS-1:0]         wb_tmask,
    input  wire word_t [NUM_THREADS-1:0]  wb_data,
    input  wire [WID_W-1:0]               rd_wid,
    input  wire reg_idx_t                 rd_reg,
    output word_t [NUM_THREADS-1:0]       rd_data
);

    localparam int NUM_REGS = 2 ** $bits(reg_idx_t);

    word_t [NUM_THREADS-1:0] regs [NUM_WARPS][NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < NUM_WARPS; w++) begin
                for (int r = 0; r < NUM_REGS; r++) begin
                    regs[w][r] <= '0;
                end
            end
        end else if (wb_valid) begin
            // inactive lanes keep their old value
            for (int i = 0; i < NUM_THREADS; i++) begin
                if (wb_tmask[i]) begin
                    regs[wb_wid][wb_rd][i] <= wb_data[i];
                end
            end
        end
    end

    assign rd_data = regs[rd_wid][rd_reg];

    a_wid_range: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> int'(wb_wid) < NUM_WARPS)
        else $error("reg_file: write to warp %0d out of range", wb_wid);

endmodule

`default_nettype wire

// File: hw/simt_backend.sv
// back-end top level, ALU and multiplier feeding the commit arbiter, commit stage and register file
`timescale 1ns/1ps
`default_nettype none

module simt_backend import simt_pkg::*; #(
    parameter int NUM_THREADS = 4,
    parameter int NUM_WARPS = 4,
    localparam int WID_W = $clog2(NUM_WARPS)
) (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           alu_valid,
    output wire                           alu_ready,
    input  wire [WID_W-1:0]               alu_wid,
    input  wire [NUM_THREADS-1:0]         alu_tmask,
    input  wire reg_idx_t                 alu_rd,
    input  wire                           alu_wb,
    input  wire                           alu_eop,
    input  wire alu_op_t                  alu_op,
    input  wire word_t [NUM_THREADS-1:0]  alu_a,
    input  wire word_t [NUM_THREADS-1:0]  alu_b,
    input  wire                           mul_valid,
    output wire                           mul_ready,
    input  wire [WID_W-1:0]               mul_wid,
    input  wire [NUM_THREADS-1:0]         mul_tmask,
    input  wire reg_idx_t                 mul_rd,
    input  wire                           mul_wb,
    input  wire                           mul_eop,
    input  wire word_t [NUM_THREADS-1:0]  mul_a,
    input  wire word_t [NUM_THREADS-1:0]  mul_b,
    output wire                           committed,
    output wire [WID_W-1:0]               committed_wid,
    output wire instret_t                 instret,
    input  wire [WID_W-1:0]               rf_rd_wid,
    input  wire reg_idx_t                 rf_rd_reg,
    output wire word_t [NUM_THREADS-1:0]  rf_rd_data
);

    wire                          alu_cm_valid, alu_cm_ready, alu_cm_wb, alu_cm_eop;
    wire [WID_W-1:0]              alu_cm_wid;
    wire [NUM_THREADS-1:0]        alu_cm_tmask;
    wire reg_idx_t                alu_cm_rd;
    wire word_t [NUM_THREADS-1:0] alu_cm_data;

    wire                          mul_cm_valid, mul_cm_ready, mul_cm_wb, mul_cm_eop;
    wire [WID_W-1:0]              mul_cm_wid;
    wire [NUM_THREADS-1:0]        mul_cm_tmask;
    wire reg_idx_t                mul_cm_rd;
    wire word_t [NUM_THREADS-1:0] mul_cm_data;

    wire                          cm_valid, cm_ready, cm_wb, cm_eop;
    wire [WID_W-1:0]              cm_wid;
    wire [NUM_THREADS-1:0]        cm_tmask;
    wire reg_idx_t                cm_rd;
    wire word_t [NUM_THREADS-1:0] cm_data;

    wire                          wb_valid;
    wire [WID_W-1:0]              wb_wid;
    wire reg_idx_t                wb_rd;
    wire [NUM_THREADS-1:0]        wb_tmask;
    wire word_t [NUM_THREADS-1:0] wb_data;

    alu_unit #(.NUM_THREADS(NUM_THREADS), .NUM_WARPS(NUM_WARPS)) u_alu (
        .clk(clk), .reset(reset),
        .in_valid(alu_valid), .in_ready(alu_ready), .in_wid(alu_wid), .in_tmask(alu_tmask),
        .in_rd(alu_rd), .in_wb(alu_wb), .in_eop(alu_eop), .in_op(alu_op),
        .in_a(alu_a), .in_b(alu_b),
        .cm_valid(alu_cm_valid), .cm_ready(alu_cm_ready), .cm_wid(alu_cm_wid),
        .cm_tmask(alu_cm_tmask), .cm_rd(alu_cm_rd), .cm_wb(alu_cm_wb),
        .cm_eop(alu_cm_eop), .cm_data(alu_cm_data)
    );

    mul_unit #(.NUM_THREADS(NUM_THREADS), .NUM_WARPS(NUM_WARPS)) u_mul (
        .clk(clk), .reset(reset),
        .in_valid(mul_valid), .in_ready(mul_ready), .in_wid(mul_wid), .in_tmask(mul_tmask),
        .in_rd(mul_rd), .in_wb(mul_wb), .in_eop(mul_eop), .in_a(mul_a), .in_b(mul_b),
        .cm_valid(mul_cm_valid), .cm_ready(mul_cm_ready), .cm_wid(mul_cm_wid),
        .cm_tmask(mul_cm_tmask), .cm_rd(mul_cm_rd), .cm_wb(mul_cm_wb),
        .cm_eop(mul_cm_eop), .cm_data(mul_cm_data)
    );

    // input 0 is the ALU, input 1 the multiplier
    commit_arb #(.NUM_THREADS(NUM_THREADS), .NUM_WARPS(NUM_WARPS)) u_arb (
        .clk(clk), .reset(reset),
        .in_valid({mul_cm_valid, alu_cm_valid}), .in_ready({mul_cm_ready, alu_cm_ready}),
        .in_wid({mul_cm_wid, alu_cm_wid}), .in_tmask({mul_cm_tmask, alu_cm_tmask}),
        .in_rd({mul_cm_rd, alu_cm_rd}), .in_wb({mul_cm_wb, alu_cm_wb}),
        .in_eop({mul_cm_eop, alu_cm_eop}), .in_data({mul_cm_data, alu_cm_data}),
        .out_valid(cm_valid), .out_ready(cm_ready), .out_wid(cm_wid), .out_tmask(cm_tmask),
        .out_rd(cm_rd), .out_wb(cm_wb), .out_eop(cm_eop), .out_data(cm_data)
    );

    commit_stage #(.NUM_THREADS(NUM_THREADS), .NUM_WARPS(NUM_WARPS)) u_commit (
        .clk(clk), .reset(reset),
        .cm_valid(cm_valid), .cm_wid(cm_wid), .cm_tmask(cm_tmask), .cm_rd(cm_rd),
        .cm_wb(cm_wb), .cm_eop(cm_eop), .cm_data(cm_data), .cm_ready(cm_ready),
        .wb_valid(wb_valid), .wb_wid(wb_wid), .wb_rd(wb_rd), .wb_tmask(wb_tmask),
        .wb_data(wb_data), .committed(committed), .committed_wid(committed_wid),
        .instret(instret)
    );

    reg_file #(.NUM_THREADS(NUM_THREADS), .NUM_WARPS(NUM_WARPS)) u_rf (
        .clk(clk), .reset(reset),
        .wb_valid(wb_valid), .wb_wid(wb_wid), .wb_rd(wb_rd), .wb_tmask(wb_tmask),
        .wb_data(wb_data), .rd_wid(rf_rd_wid), .rd_reg(rf_rd_reg), .rd_data(rf_rd_data)
    );

endmodule

`default_nettype wire

// File: testbench/simt_backend_tb.sv
// table-driven testbench for the SIMT back end, run as the simulation top with the file list
`timescale 1ns/1ps
`default_nettype none

module simt_backend_tb import simt_pkg::*;;

    localparam int NUM_THREADS = 4;
    localparam int NUM_WARPS = 4;
    localparam int WID_W = $clog2(NUM_WARPS);
    localparam int NUM_REGS = 8;
    localparam int NUM_ROWS = 14;
    localparam int TIMEOUT_CYCLES = 40 * NUM_ROWS + 200;
    localparam bit UNIT_ALU = 1'b0;
    localparam bit UNIT_MUL = 1'b1;

    typedef struct packed {
        logic                   unit;
        logic [WID_W-1:0]       wid;
        logic [NUM_THREADS-1:0] tmask;
        reg_idx_t               rd;
        logic                   wb;
        logic                   eop;
        alu_op_t                op;
        word_t                  a_base;
        word_t                  b_base;
    } row_t;

    logic clk = 1'b0;
    logic reset;

    logic                    alu_valid;
    wire                     alu_ready;
    logic [WID_W-1:0]        alu_wid;
    logic [NUM_THREADS-1:0]  alu_tmask;
    reg_idx_t                alu_rd;
    logic                    alu_wb;
    logic                    alu_eop;
    alu_op_t                 alu_op;
    word_t [NUM_THREADS-1:0] alu_a;
    word_t [NUM_THREADS-1:0] alu_b;
    logic                    mul_valid;
    wire                     mul_ready;
    logic [WID_W-1:0]        mul_wid;
    logic [NUM_THREADS-1:0]  mul_tmask;
    reg_idx_t                mul_rd;
    logic                    mul_wb;
    logic                    mul_eop;
    word_t [NUM_THREADS-1:0] mul_a;
    word_t [NUM_THREADS-1:0] mul_b;
    wire                     committed;
    wire [WID_W-1:0]         committed_wid;
    wire instret_t           instret;
    logic [WID_W-1:0]        rf_rd_wid;
    reg_idx_t                rf_rd_reg;
    wire word_t [NUM_THREADS-1:0] rf_rd_data;

    row_t  table_rows [NUM_ROWS];
    word_t exp_rf [NUM_WARPS][NUM_REGS][NUM_THREADS];
    int    exp_commits [NUM_WARPS];
    int    commit_count [NUM_WARPS];
    int    exp_instret;
    int    cycle_count = 0;

    simt_backend #(.NUM_THREADS(NUM_THREADS), .NUM_WARPS(NUM_WARPS)) u_dut (
        .clk(clk), .reset(reset),
        .alu_valid(alu_valid), .alu_ready(alu_ready), .alu_wid(alu_wid),
        .alu_tmask(alu_tmask), .alu_rd(alu_rd), .alu_wb(alu_wb), .alu_eop(alu_eop),
        .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b),
        .mul_valid(mul_valid), .mul_ready(mul_ready), .mul_wid(mul_wid),
        .mul_tmask(mul_tmask), .mul_rd(mul_rd), .mul_wb(mul_wb), .mul_eop(mul_eop),
        .mul_a(mul_a), .mul_b(mul_b),
        .committed(committed), .committed_wid(committed_wid), .instret(instret),
        .rf_rd_wid(rf_rd_wid), .rf_rd_reg(rf_rd_reg), .rf_rd_data(rf_rd_data)
    );

    always #50 clk = ~clk;

    // watchdog on the whole run
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: run hung, no finish after %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    always @(posedge clk) begin
        if (!reset && committed) begin
            commit_count[committed_wid] <= commit_count[committed_wid] + 1;
        end
    end

    function automatic row_t make_row(input bit unit, input int wid, input int tmask,
                                      input int rd, input bit wb, input bit eop,
                                      input alu_op_t op, input word_t a_base,
                                      input word_t b_base);
        row_t row;
        row.unit   = unit;
        row.wid    = WID_W'(wid);
        row.tmask  = NUM_THREADS'(tmask);
        row.rd     = reg_idx_t'(rd);
        row.wb     = wb;
        row.eop    = eop;
        row.op     = op;
        row.a_base = a_base;
        row.b_base = b_base;
        return row;
    endfunction

    // unit, wid, tmask, rd, wb, eop, op, a base, b base
    task automatic fill_table;
        table_rows[0]  = make_row(UNIT_ALU, 0, 4'b1111, 1, 1, 1, ALU_ADD, 32'h10, 32'h100);
        table_rows[1]  = make_row(UNIT_MUL, 0, 4'b1111, 2, 1, 1, ALU_ADD, 32'h3, 32'h7);
        table_rows[2]  = make_row(UNIT_MUL, 1, 4'b0111, 2, 1, 1, ALU_ADD, 32'h1234, 32'h11);
        table_rows[3]  = make_row(UNIT_ALU, 1, 4'b1010, 0, 1, 0, ALU_SUB, 32'h50, 32'h60);
        table_rows[4]  = make_row(UNIT_ALU, 1, 4'b1111, 3, 1, 1, ALU_AND, 32'hf0f0, 32'hff00);
        table_rows[5]  = make_row(UNIT_MUL, 2, 4'b1101, 5, 1, 0, ALU_ADD, 32'h10000, 32'h10003);
        table_rows[6]  = make_row(UNIT_MUL, 2, 4'b1000, 6, 0, 1, ALU_ADD, 32'h5, 32'h6);
        table_rows[7]  = make_row(UNIT_ALU, 2, 4'b1111, 7, 0, 0, ALU_XOR, 32'h77, 32'h88);
        table_rows[8]  = make_row(UNIT_ALU, 3, 4'b0011, 4, 1, 1, ALU_XOR, 32'haaaa5555,
                                  32'h0f0f0f0f);
        table_rows[9]  = make_row(UNIT_MUL, 3, 4'b1111, 1, 1, 1, ALU_ADD, 32'hfffffff0, 32'h3);
        table_rows[10] = make_row(UNIT_ALU, 0, 4'b0100, 6, 1, 0, ALU_ADD, 32'hffffffff, 32'h1);
        table_rows[11] = make_row(UNIT_MUL, 1, 4'b1110, 7, 1, 1, ALU_ADD, 32'h7fff, 32'h8001);
        table_rows[12] = make_row(UNIT_ALU, 3, 4'b1111, 0, 1, 1, ALU_SUB, 32'h0, 32'h5);
        table_rows[13] = make_row(UNIT_MUL, 0, 4'b1011, 3, 1, 0, ALU_ADD, 32'hdead, 32'hbeef);
    endtask

    // lane i works on base plus i
    function automatic word_t lane_result(input row_t row, input int lane);
        word_t a;
        word_t b;
        word_t product;
        a = row.a_base + word_t'(lane);
        b = row.b_base + word_t'(lane);
        product = a * b;
        if (row.unit == UNIT_MUL) begin
            return product;
        end
        case (row.op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            default: return a ^ b;
        endcase
    endfunction

    task automatic build_expected;
        for (int w = 0; w < NUM_WARPS; w++) begin
            exp_commits[w] = 0;
            commit_count[w] = 0;
            for (int r = 0; r < NUM_REGS; r++) begin
                for (int i = 0; i < NUM_THREADS; i++) begin
                    exp_rf[w][r][i] = '0;
                end
            end
        end
        exp_instret = 0;
        for (int n = 0; n < NUM_ROWS; n++) begin
            exp_instret += $countones(table_rows[n].tmask);
            if (table_rows[n].eop) begin
                exp_commits[table_rows[n].wid]++;
            end
            for (int i = 0; i < NUM_THREADS; i++) begin
                if (table_rows[n].wb && table_rows[n].tmask[i]) begin
                    exp_rf[table_rows[n].wid][table_rows[n].rd][i] =
                        lane_result(table_rows[n], i);
                end
            end
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic set_valid(input bit unit, input logic value);
        if (unit == UNIT_MUL) begin
            mul_valid <= value;
        end else begin
            alu_valid <= value;
        end
    endtask

    task automatic drive_row(input int n);
        row_t row;
        word_t [NUM_THREADS-1:0] a_vec;
        word_t [NUM_THREADS-1:0] b_vec;
        row = table_rows[n];
        for (int i = 0; i < NUM_THREADS; i++) begin
            a_vec[i] = row.a_base + word_t'(i);
            b_vec[i] = row.b_base + word_t'(i);
        end
        if (row.unit == UNIT_MUL) begin
            mul_valid <= 1'b1;
            mul_wid   <= row.wid;
            mul_tmask <= row.tmask;
            mul_rd    <= row.rd;
            mul_wb    <= row.wb;
            mul_eop   <= row.eop;
            mul_a     <= a_vec;
            mul_b     <= b_vec;
        end else begin
            alu_valid <= 1'b1;
            alu_wid   <= row.wid;
            alu_tmask <= row.tmask;
            alu_rd    <= row.rd;
            alu_wb    <= row.wb;
            alu_eop   <= row.eop;
            alu_op    <= row.op;
            alu_a     <= a_vec;
            alu_b     <= b_vec;
        end
    endtask

    // ready is sampled mid-cycle, the transfer is the following edge
    task automatic wait_accept(input bit unit);
        do begin
            @(negedge clk);
        end while (!((unit == UNIT_MUL) ? mul_ready : alu_ready));
        @(posedge clk);
    endtask

    task automatic issue_rows(input bit unit);
        int issued;
        int gap;
        issued = 0;
        for (int n = 0; n < NUM_ROWS; n++) begin
            if (table_rows[n].unit == unit) begin
                // first two rows per unit go back to back, both units together
                gap = (issued < 2) ? 0 : int'($urandom % 3);
                if (gap > 0) begin
                    set_valid(unit, 1'b0);
                    repeat (gap) @(posedge clk);
                end
                drive_row(n);
                wait_accept(unit);
                issued++;
            end
        end
        set_valid(unit, 1'b0);
    endtask

    initial begin
        void'($urandom(32'hda2ede03));
        fill_table();
        build_expected();
        reset = 1'b1;
        alu_valid = 1'b0;
        alu_wid = '0;
        alu_tmask = '0;
        alu_rd = '0;
        alu_wb = 1'b0;
        alu_eop = 1'b0;
        alu_op = ALU_ADD;
        alu_a = '0;
        alu_b = '0;
        mul_valid = 1'b0;
        mul_wid = '0;
        mul_tmask = '0;
        mul_rd = '0;
        mul_wb = 1'b0;
        mul_eop = 1'b0;
        mul_a = '0;
        mul_b = '0;
        rf_rd_wid = '0;
        rf_rd_reg = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("committed", 32'h0, 32'(committed));
        check_value("instret", 32'h0, instret);
        @(posedge clk);
        fork
            issue_rows(UNIT_ALU);
            issue_rows(UNIT_MUL);
        join
        repeat (20) @(posedge clk);
        check_value("instret", 32'(exp_instret), instret);
        for (int w = 0; w < NUM_WARPS; w++) begin
            check_value($sformatf("committed count wid %0d", w), 32'(exp_commits[w]),
                        32'(commit_count[w]));
        end
        // sweep every warp and register through the read port
        for (int w = 0; w < NUM_WARPS; w++) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                @(posedge clk);
                rf_rd_wid <= WID_W'(w);
                rf_rd_reg <= reg_idx_t'(r);
                @(negedge clk);
                for (int i = 0; i < NUM_THREADS; i++) begin
                    check_value($sformatf("rf_rd_data w%0d r%0d lane %0d", w, r, i),
                                exp_rf[w][r][i], rf_rd_data[i]);
                end
            end
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: simt_backend.f
common/simt_pkg.sv
hw/alu_unit.sv
hw/mul_unit.sv
commit/commit_arb.sv
commit/commit_stage.sv
hw/reg_file.sv
hw/simt_backend.sv
testbench/simt_backend_tb.sv

// File: Bender.yml
package:
  name: simt_backend

sources:
  - common/simt_pkg.sv
  - hw/alu_unit.sv
  - hw/mul_unit.sv
  - commit/commit_arb.sv
  - commit/commit_stage.sv
  - hw/reg_file.sv
  - hw/simt_backend.sv
  - target: simulation
    files:
      - testbench/simt_backend_tb.sv
